//--- aes_ctr_sub.f
hw/aes_ctr_pkg.sv
hw/aes_ctr_sparse_chk.sv
hw/aes_ctr_fsm.sv
hw/aes_ctr_reg.sv
hw/aes_ctr.sv
hw/aes_ctr_top.sv
dv/aes_ctr_tb.sv

//--- Makefile
SIM      = verilator
TOP      = aes_ctr_tb
FILELIST = aes_ctr_sub.f
FLAGS    = --binary --timing --assert -j 0
OBJ_DIR  = obj_dir
BIN      = $(OBJ_DIR)/V$(TOP)
LOG      = sim.log
FAIL_MSG = TEST RESULT: FAIL
SRCS     = $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- dv/aes_ctr_tb.sv
// AES CTR counter stage testbench
// Table of loads and increments checked against a big-endian add-one model
`timescale 1ns/100ps
`default_nettype none

module aes_ctr_tb;

  typedef enum logic [1:0] {
    OP_LOAD_INCR,
    OP_INCR,
    OP_BAD_CODE
  } op_e;

  // One table row with iv ignored by OP_INCR
  typedef struct packed {
    op_e                    op;
    aes_ctr_pkg::ctr_word_u iv;
    logic [3:0]             n_incr;
  } entry_t;

  localparam int NumEntries    = 12;
  // Two drive cycles plus check stage, eight writes and sampling slack
  localparam int CyclesPerStep = 12;

  logic                   clk;
  logic                   rst_n;
  logic                   load;
  aes_ctr_pkg::ctr_word_u iv;
  aes_ctr_pkg::sp2v_e     incr;
  aes_ctr_pkg::sp2v_e     ready;
  aes_ctr_pkg::ctr_word_u ctr;
  logic                   alert;

  entry_t                 stim [NumEntries];
  aes_ctr_pkg::ctr_word_u exp_ctr;
  logic [31:0]            lfsr;
  int                     errors;
  int                     pass_cnt;
  int                     fail_cnt;

  aes_ctr_top aes_ctr_top_i (
    .clk_i   ( clk   ),
    .rst_n_i ( rst_n ),
    .load_i  ( load  ),
    .iv_i    ( iv    ),
    .incr_i  ( incr  ),
    .ready_o ( ready ),
    .ctr_o   ( ctr   ),
    .alert_o ( alert )
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus and reference model

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_step(logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // One LFSR step per bit
  function automatic aes_ctr_pkg::ctr_word_u rand_word();
    logic [aes_ctr_pkg::CtrWidth-1:0] bits;
    for (int i = 0; i < aes_ctr_pkg::CtrWidth; i++) begin
      lfsr    = lfsr_step(lfsr);
      bits[i] = lfsr[0];
    end
    return bits;
  endfunction

  // Least significant bytes sit at the end of the string
  function automatic aes_ctr_pkg::ctr_word_u set_low_bytes(aes_ctr_pkg::ctr_word_u w, int n);
    for (int i = 0; i < n; i++) begin
      w.bytes[aes_ctr_pkg::CtrWidth/8 - 1 - i] = 8'hff;
    end
    return w;
  endfunction

  // Add one to a big-endian byte string with the carry walking toward byte 0
  function automatic aes_ctr_pkg::ctr_word_u add_one_be(aes_ctr_pkg::ctr_word_u w);
    logic carry;
    carry = 1'b1;
    for (int i = aes_ctr_pkg::CtrWidth/8 - 1; i >= 0; i--) begin
      if (carry) begin
        w.bytes[i] = w.bytes[i] + 8'd1;
        carry      = (w.bytes[i] == 8'h00);
      end
    end
    return w;
  endfunction

  function automatic entry_t make_entry(op_e op, aes_ctr_pkg::ctr_word_u w, logic [3:0] n);
    entry_t e;
    e.op     = op;
    e.iv     = w;
    e.n_incr = n;
    return e;
  endfunction

  task automatic build_table();
    aes_ctr_pkg::ctr_word_u w;
    stim[0] = make_entry(OP_LOAD_INCR, rand_word(), 4'd1);
    // Carry over one, three and seven slices
    stim[1] = make_entry(OP_LOAD_INCR, set_low_bytes(rand_word(), 2), 4'd1);
    stim[2] = make_entry(OP_LOAD_INCR, set_low_bytes(rand_word(), 6), 4'd1);
    stim[3] = make_entry(OP_LOAD_INCR, set_low_bytes(rand_word(), 14), 4'd1);
    // Wrap and keep counting from zero
    stim[4] = make_entry(OP_LOAD_INCR, '1, 4'd1);
    stim[5] = make_entry(OP_INCR, '0, 4'd3);
    // Low slice 0xfffd so the carry shows up on the third step
    w = set_low_bytes(rand_word(), 2);
    w.bytes[aes_ctr_pkg::CtrWidth/8 - 1] = 8'hfd;
    stim[6] = make_entry(OP_LOAD_INCR, w, 4'd4);
    stim[7] = make_entry(OP_LOAD_INCR, rand_word(), 4'd5);
    stim[8] = make_entry(OP_INCR, '0, 4'd2);
    stim[9] = make_entry(OP_LOAD_INCR, '1, 4'd1);
    // Nonzero count for the fault to freeze and the reset to clear
    stim[10] = make_entry(OP_LOAD_INCR, rand_word(), 4'd1);
    stim[11] = make_entry(OP_BAD_CODE, '0, 4'd2);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Checks

  task automatic check_word(string sig, aes_ctr_pkg::ctr_word_u got,
                            aes_ctr_pkg::ctr_word_u exp);
    if (got !== exp) begin
      errors++;
      $display("error: time %0t %s got %h expected %h", $time, sig, got, exp);
    end
  endtask

  task automatic check_sp2v(string sig, aes_ctr_pkg::sp2v_e got, aes_ctr_pkg::sp2v_e exp);
    if (got !== exp) begin
      errors++;
      $display("error: time %0t %s got %b expected %b", $time, sig, got, exp);
    end
  endtask

  task automatic check_bit(string sig, logic got, logic exp);
    if (got !== exp) begin
      errors++;
      $display("error: time %0t %s got %b expected %b", $time, sig, got, exp);
    end
  endtask

  // Values right after reset
  task automatic check_idle();
    check_sp2v("ready_o", ready, aes_ctr_pkg::SP2V_HIGH);
    check_word("ctr_o", ctr, '0);
    check_bit("alert_o", alert, 1'b0);
  endtask

  task automatic report_test(string name, int errs_before);
    if (errors == errs_before) begin
      pass_cnt++;
      $display("test %s passed", name);
    end else begin
      fail_cnt++;
      $display("test %s failed with %0d errors", name, errors - errs_before);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Bus actions

  task automatic apply_reset();
    @(posedge clk);
    rst_n <= 1'b0;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
  endtask

  // ctr_o shows the new value one cycle after the pulse
  task automatic load_word(aes_ctr_pkg::ctr_word_u w);
    @(posedge clk);
    load <= 1'b1;
    iv   <= w;
    @(posedge clk);
    load <= 1'b0;
    @(negedge clk);
  endtask

  // One-cycle request followed by busy and back to ready
  task automatic request_incr();
    @(posedge clk);
    incr <= aes_ctr_pkg::SP2V_HIGH;
    @(posedge clk);
    incr <= aes_ctr_pkg::SP2V_LOW;
    do begin
      @(negedge clk);
    end while (ready !== aes_ctr_pkg::SP2V_LOW);
    do begin
      @(negedge clk);
    end while (ready !== aes_ctr_pkg::SP2V_HIGH);
  endtask

  // Invalid code locks the stage so later requests go nowhere
  task automatic run_bad_code(int n);
    aes_ctr_pkg::ctr_word_u frozen;
    frozen = ctr;
    @(posedge clk);
    incr <= aes_ctr_pkg::sp2v_e'(3'b000);
    @(posedge clk);
    incr <= aes_ctr_pkg::SP2V_LOW;
    do begin
      @(negedge clk);
    end while (alert !== 1'b1);
    repeat (n) begin
      @(posedge clk);
      incr <= aes_ctr_pkg::SP2V_HIGH;
      @(posedge clk);
      incr <= aes_ctr_pkg::SP2V_LOW;
      // Longer than any legal increment
      repeat (CyclesPerStep) @(posedge clk);
      @(negedge clk);
      check_sp2v("ready_o", ready, aes_ctr_pkg::SP2V_LOW);
      check_word("ctr_o", ctr, frozen);
      check_bit("alert_o", alert, 1'b1);
    end
    apply_reset();
    exp_ctr = '0;
    check_idle();
  endtask

  task automatic run_entry(int idx, entry_t e);
    int errs_before;
    errs_before = errors;
    if (e.op == OP_BAD_CODE) begin
      run_bad_code(e.n_incr);
    end else begin
      if (e.op == OP_LOAD_INCR) begin
        load_word(e.iv);
        exp_ctr = e.iv;
        check_word("ctr_o", ctr, exp_ctr);
      end
      repeat (e.n_incr) begin
        request_incr();
        exp_ctr = add_one_be(exp_ctr);
        check_word("ctr_o", ctr, exp_ctr);
        check_bit("alert_o", alert, 1'b0);
      end
    end
    report_test($sformatf("%0d %s", idx, e.op.name()), errs_before);
  endtask

  task automatic run_watchdog(int limit);
    int cycles;
    cycles = 0;
    while (cycles < limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: no result after %0d cycles", limit);
    $display("TEST RESULT: FAIL");
    $finish;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence

  initial begin
    int limit;
    rst_n    = 1'b0;
    load     = 1'b0;
    iv       = '0;
    incr     = aes_ctr_pkg::SP2V_LOW;
    exp_ctr  = '0;
    lfsr     = 32'ha891;
    errors   = 0;
    pass_cnt = 0;
    fail_cnt = 0;
    build_table();
    // Budget per increment plus reset and load overhead
    limit = 100;
    for (int i = 0; i < NumEntries; i++) begin
      limit += (int'(stim[i].n_incr) + 1) * CyclesPerStep;
    end
    fork
      run_watchdog(limit);
    join_none
    apply_reset();
    check_idle();
    report_test("reset", 0);
    for (int i = 0; i < NumEntries; i++) begin
      run_entry(i, stim[i]);
    end
    $display("tests passed %0d failed %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- hw/aes_ctr_top.sv
// AES CTR counter stage top level
// Counter register plus redundant increment control
`timescale 1ns/100ps
`default_nettype none

module aes_ctr_top (
  input  wire logic                     clk_i,
  input  wire logic                     rst_n_i,
  input  wire logic                     load_i,
  input  wire aes_ctr_pkg::ctr_word_u   iv_i,
  input  wire aes_ctr_pkg::sp2v_e       incr_i,
  output aes_ctr_pkg::sp2v_e            ready_o,
  output aes_ctr_pkg::ctr_word_u        ctr_o,
  output logic                          alert_o
);

  // Word computed by control, written back slice-wise
  aes_ctr_pkg::ctr_word_u      ctr_upd;
  aes_ctr_pkg::ctr_slice_we_t  ctr_we;

  ////////////////////////////////////////////////////////////////////////////
  // Storage
  aes_ctr_reg u_reg (
    .clk_i    ( clk_i   ),
    .rst_n_i  ( rst_n_i ),
    .load_i   ( load_i  ),
    .iv_i     ( iv_i    ),
    .ctr_i    ( ctr_upd ),
    .ctr_we_i ( ctr_we  ),
    .ctr_o    ( ctr_o   )
  );

  ////////////////////////////////////////////////////////////////////////////
  // Control
  aes_ctr u_ctr (
    .clk_i    ( clk_i   ),
    .rst_n_i  ( rst_n_i ),
    .incr_i   ( incr_i  ),
    .ready_o  ( ready_o ),
    .alert_o  ( alert_o ),
    // Current value in, updated value out
    .ctr_i    ( ctr_o   ),
    .ctr_o    ( ctr_upd ),
    .ctr_we_o ( ctr_we  )
  );

endmodule

`default_nettype wire

//--- hw/aes_ctr.sv
// AES CTR counter control
// Redundant rails increment the counter one slice at a time and cross-check each other
`timescale 1ns/100ps
`default_nettype none

module aes_ctr (
  input  wire logic                          clk_i,
  input  wire logic                          rst_n_i,
  input  wire aes_ctr_pkg::sp2v_e            incr_i,
  output aes_ctr_pkg::sp2v_e                 ready_o,
  output logic                               alert_o,
  input  wire aes_ctr_pkg::ctr_word_u        ctr_i,
  output aes_ctr_pkg::ctr_word_u             ctr_o,
  output aes_ctr_pkg::ctr_slice_we_t         ctr_we_o
);

  // Byte swap between string order and integer order
  function automatic aes_ctr_pkg::ctr_word_u rev_bytes(aes_ctr_pkg::ctr_word_u w);
    aes_ctr_pkg::ctr_word_u r;
    for (int i = 0; i < aes_ctr_pkg::CtrWidth / 8; i++) begin
      r.bytes[i] = w.bytes[aes_ctr_pkg::CtrWidth/8 - 1 - i];
    end
    return r;
  endfunction

  aes_ctr_pkg::ctr_word_u                   ctr_i_rev;
  aes_ctr_pkg::ctr_word_u                   ctr_o_rev;
  logic [aes_ctr_pkg::SliceSize-1:0]        ctr_i_slice;
  logic [aes_ctr_pkg::SliceSize-1:0]        ctr_o_slice;
  logic [aes_ctr_pkg::SliceIdxWidth-1:0]    ctr_slice_idx;
  aes_ctr_pkg::sp2v_e                       ctr_we;

  logic [aes_ctr_pkg::Sp2VWidth-1:0]        incr_raw;
  logic                                     incr_err;
  logic                                     mr_err;

  // One entry per rail
  aes_ctr_pkg::ctr_rail_t [aes_ctr_pkg::Sp2VWidth-1:0] rails;
  logic [aes_ctr_pkg::Sp2VWidth-1:0]        sp_ready;
  logic [aes_ctr_pkg::Sp2VWidth-1:0]        sp_we;
  logic [aes_ctr_pkg::Sp2VWidth-1:0]        mr_alert;

  ////////////////////////////////////////////////////////////////////////////
  // Inputs

  assign ctr_i_rev = rev_bytes(ctr_i);

  // Registered, checked request
  aes_ctr_sparse_chk u_incr_chk (
    .clk_i   ( clk_i    ),
    .rst_n_i ( rst_n_i  ),
    .sel_i   ( incr_i   ),
    .sel_o   ( incr_raw ),
    .err_o   ( incr_err )
  );

  // Slice under work, picked by the agreed index
  assign ctr_i_slice = ctr_i_rev.slices[ctr_slice_idx];

  ////////////////////////////////////////////////////////////////////////////
  // Redundant rails

  // Each rail gets one bit of the sparse request
  for (genvar i = 0; i < aes_ctr_pkg::Sp2VWidth; i++) begin : gen_rail
    aes_ctr_fsm #(
      .RailActiveHigh ( aes_ctr_pkg::SP2V_LOGIC_HIGH[i] )
    ) u_fsm (
      .clk_i       ( clk_i       ),
      .rst_n_i     ( rst_n_i     ),
      .incr_i      ( incr_raw[i] ),
      .incr_err_i  ( incr_err    ),
      .mr_err_i    ( mr_err      ),
      .ctr_slice_i ( ctr_i_slice ),
      .rail_o      ( rails[i]    )
    );
  end

  // OR-combine the rails, then hold each one against the result
  always_comb begin
    ctr_slice_idx = '0;
    ctr_o_slice   = '0;
    mr_err        = 1'b0;

    for (int i = 0; i < aes_ctr_pkg::Sp2VWidth; i++) begin
      sp_ready[i]    = rails[i].ready;
      sp_we[i]       = rails[i].we;
      mr_alert[i]    = rails[i].alert;
      ctr_slice_idx |= rails[i].slice_idx;
      ctr_o_slice   |= rails[i].slice;
    end

    // Any rail off the combined value is a fault
    for (int i = 0; i < aes_ctr_pkg::Sp2VWidth; i++) begin
      if ((rails[i].slice_idx != ctr_slice_idx) || (rails[i].slice != ctr_o_slice)) begin
        mr_err = 1'b1;
      end
    end
  end

  // Rail bits back into sparse codes
  assign ready_o = aes_ctr_pkg::sp2v_e'(sp_ready);
  assign ctr_we  = aes_ctr_pkg::sp2v_e'(sp_we);

  // One alerting rail is enough
  assign alert_o = |mr_alert;

  ////////////////////////////////////////////////////////////////////////////
  // Outputs

  // Updated slice dropped into the integer-order word
  always_comb begin
    ctr_o_rev                      = ctr_i_rev;
    ctr_o_rev.slices[ctr_slice_idx] = ctr_o_slice;
  end

  // Enables in integer order, register maps them back
  always_comb begin
    ctr_we_o                = {aes_ctr_pkg::NumSlices{aes_ctr_pkg::SP2V_LOW}};
    ctr_we_o[ctr_slice_idx] = ctr_we;
  end

  assign ctr_o = rev_bytes(ctr_o_rev);

  // Rails that disagree end up alerting next cycle
  a_alert_on_mismatch : assert property (
    @(posedge clk_i) disable iff (!rst_n_i) mr_err |=> alert_o
  );

endmodule

`default_nettype wire

//--- hw/aes_ctr_reg.sv
// AES CTR counter register
// Holds the 128-bit counter, loads the initial value and writes selected slices
`timescale 1ns/100ps
`default_nettype none

module aes_ctr_reg (
  input  wire logic                          clk_i,
  input  wire logic                          rst_n_i,
  input  wire logic                          load_i,
  input  wire aes_ctr_pkg::ctr_word_u        iv_i,
  input  wire aes_ctr_pkg::ctr_word_u        ctr_i,
  input  wire aes_ctr_pkg::ctr_slice_we_t    ctr_we_i,
  output aes_ctr_pkg::ctr_word_u             ctr_o
);

  aes_ctr_pkg::ctr_word_u                 ctr_q;
  // Per-slice write strobe in storage order
  logic [aes_ctr_pkg::NumSlices-1:0]      we_high;

  // Enables come in integer order
  // Integer slice k covers string bytes of storage slice NumSlices-1-k
  always_comb begin
    for (int j = 0; j < aes_ctr_pkg::NumSlices; j++) begin
      we_high[j] = (ctr_we_i[aes_ctr_pkg::NumSlices-1-j] == aes_ctr_pkg::SP2V_HIGH);
    end
  end

  // Load wins over slice writes
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ctr_q <= '0;
    end else if (load_i) begin
      ctr_q <= iv_i;
    end else begin
      for (int j = 0; j < aes_ctr_pkg::NumSlices; j++) begin
        if (we_high[j]) begin
          ctr_q.slices[j] <= ctr_i.slices[j];
        end
      end
    end
  end

  assign ctr_o = ctr_q;

  // Control walks one slice at a time
  a_one_slice_we : assert property (
    @(posedge clk_i) disable iff (!rst_n_i) $onehot0(we_high)
  );

endmodule

`default_nettype wire

//--- hw/aes_ctr_fsm.sv
// Single-rail counter controller
// Walks the counter slice by slice while the carry propagates, polarity set per rail
`timescale 1ns/100ps
`default_nettype none

module aes_ctr_fsm #(
  parameter bit RailActiveHigh = 1'b1
) (
  input  wire logic                                 clk_i,
  input  wire logic                                 rst_n_i,
  input  wire logic                                 incr_i,
  input  wire logic                                 incr_err_i,
  input  wire logic                                 mr_err_i,
  input  wire logic [aes_ctr_pkg::SliceSize-1:0]    ctr_slice_i,
  output aes_ctr_pkg::ctr_rail_t                    rail_o
);

  // Sparse state codes, min Hamming distance 3
  localparam logic [5:0] StIdle  = 6'b100101;
  localparam logic [5:0] StIncr  = 6'b011011;
  localparam logic [5:0] StError = 6'b110010;

  localparam logic [aes_ctr_pkg::SliceSize-1:0] SliceOne =
      {{(aes_ctr_pkg::SliceSize-1){1'b0}}, 1'b1};
  localparam logic [aes_ctr_pkg::SliceIdxWidth-1:0] IdxOne =
      {{(aes_ctr_pkg::SliceIdxWidth-1){1'b0}}, 1'b1};
  // Slice count is a power of two
  localparam logic [aes_ctr_pkg::SliceIdxWidth-1:0] LastIdx =
      {aes_ctr_pkg::SliceIdxWidth{1'b1}};

  logic [5:0]                              state_q, state_d;
  logic [aes_ctr_pkg::SliceIdxWidth-1:0]   idx_q, idx_d;
  logic                                    incr;
  logic                                    carry;
  logic                                    ready;
  logic                                    we;
  logic                                    alert;

  // Rail-local view of the request
  assign incr = (incr_i == RailActiveHigh);

  // All ones in the slice means the add ripples into the next one
  assign carry = (ctr_slice_i == {aes_ctr_pkg::SliceSize{1'b1}});

  ////////////////////////////////////////////////////////////////////////////
  // Next state
  always_comb begin
    state_d = state_q;
    idx_d   = idx_q;
    ready   = 1'b0;
    we      = 1'b0;
    alert   = 1'b0;

    case (state_q)
      StIdle: begin
        ready = 1'b1;
        // Start at the least significant slice
        if (incr) begin
          idx_d   = '0;
          state_d = StIncr;
        end
      end

      StIncr: begin
        we = 1'b1;
        if (carry && (idx_q != LastIdx)) begin
          idx_d = idx_q + IdxOne;
        end else begin
          // Carry absorbed, or wrapped past the top slice
          idx_d   = '0;
          state_d = StIdle;
        end
      end

      // Terminal until reset
      StError: begin
        alert = 1'b1;
      end

      // Any corrupted state code
      default: begin
        alert   = 1'b1;
        state_d = StError;
      end
    endcase

    // Input fault or rail disagreement overrides everything
    if (incr_err_i || mr_err_i) begin
      state_d = StError;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= StIdle;
      idx_q   <= '0;
    end else begin
      state_q <= state_d;
      idx_q   <= idx_d;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Outputs
  assign rail_o.slice_idx = idx_q;
  assign rail_o.slice     = ctr_slice_i + SliceOne;
  // Back into rail polarity
  assign rail_o.ready     = RailActiveHigh ? ready : ~ready;
  assign rail_o.we        = RailActiveHigh ? we : ~we;
  assign rail_o.alert     = alert;

  // No slice write from an idle rail
  a_no_we_in_idle : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    (state_q == StIdle) |-> (rail_o.we != RailActiveHigh)
  );

endmodule

`default_nettype wire

//--- hw/aes_ctr_sparse_chk.sv
// Sparse signal check
// Registers a sparse two-value signal and flags any code outside the valid pair
`timescale 1ns/100ps
`default_nettype none

module aes_ctr_sparse_chk (
  input  wire logic                             clk_i,
  input  wire logic                             rst_n_i,
  input  wire aes_ctr_pkg::sp2v_e               sel_i,
  output logic [aes_ctr_pkg::Sp2VWidth-1:0]     sel_o,
  output logic                                  err_o
);

  logic [aes_ctr_pkg::Sp2VWidth-1:0] sel_q;
  logic                              err_q;
  logic                              sel_valid;

  // Only the two sparse codes are legal
  assign sel_valid = (sel_i == aes_ctr_pkg::SP2V_HIGH) || (sel_i == aes_ctr_pkg::SP2V_LOW);

  // One register stage, idle value is the inactive code
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sel_q <= aes_ctr_pkg::SP2V_LOW;
      err_q <= 1'b0;
    end else begin
      sel_q <= sel_i;
      err_q <= !sel_valid;
    end
  end

  assign sel_o = sel_q;
  assign err_o = err_q;

  // Fault reported in step with the registered value
  a_err_follows_bad_code : assert property (
    @(posedge clk_i) disable iff (!rst_n_i) !sel_valid |=> err_o
  );

endmodule

`default_nettype wire

//--- hw/aes_ctr_pkg.sv
// AES CTR counter stage shared definitions
// Sparse two-value encoding, counter widths, counter word and rail bundle
`default_nettype none

package aes_ctr_pkg;

  // Number of rails, one per bit of the sparse encoding
  localparam int Sp2VWidth = 3;

  // Sparse two-value code, min Hamming distance 3
  // Anything else is a fault
  typedef enum logic [Sp2VWidth-1:0] {
    SP2V_HIGH = 3'b011,
    SP2V_LOW  = 3'b100
  } sp2v_e;

  // Rails whose bit is set in SP2V_HIGH run active high
  // Rails 0 and 1 active high, rail 2 active low
  localparam logic [Sp2VWidth-1:0] SP2V_LOGIC_HIGH = SP2V_HIGH;

  // Counter geometry
  localparam int CtrWidth      = 128;
  localparam int SliceSize     = 16;
  localparam int NumSlices     = CtrWidth / SliceSize;
  localparam int SliceIdxWidth = 3;

  // Counter word as a byte string
  // Byte 0 of the string sits in bits 7:0, so the word is big endian by string
  // order and needs a byte swap before slice arithmetic
  typedef union packed {
    logic [CtrWidth/8-1:0][7:0]           bytes;
    // Only meaningful after the byte swap, slice 0 least significant
    logic [NumSlices-1:0][SliceSize-1:0]  slices;
  } ctr_word_u;

  // One sparse write enable per slice
  typedef sp2v_e [NumSlices-1:0] ctr_slice_we_t;

  // Outputs of a single controller rail
  // ready and we are in the rail's own polarity
  typedef struct packed {
    logic [SliceIdxWidth-1:0] slice_idx;
    logic [SliceSize-1:0]     slice;
    logic                     ready;
    logic                     we;
    logic                     alert;
  } ctr_rail_t;

endpackage

`default_nettype wire
